// File: sources.f
+incdir+tests
src/dzPkg.sv
src/dzModemSync.sv
src/dzUartTx.sv
src/dzTxScan.sv
src/dzBusCtrl.sv
src/dzTop.sv
tests/dzTb.sv

// File: Makefile
# Verilator build and run for the terminal multiplexer testbench
# Override on the command line, e.g. make SEED=1234

VERILATOR ?= verilator
TOP       ?= dzTb
SEED      ?= 65990
OBJDIR    ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GseedInit=$(SEED) --Mdir $(OBJDIR) -o V$(TOP)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// File: tests/dzTbChecks.svh
////////////////////////////////////////////////////////////
// Compare tasks for the multiplexer testbench
// Included inside the testbench module body
// Relies on errCount and abortRun from the including module
// First mismatch ends the run
////////////////////////////////////////////////////////////

`ifndef DZ_TB_CHECKS_SVH
`define DZ_TB_CHECKS_SVH

// Bus data word, seen through the register union
task automatic checkWord(input string name, input dzPkg::regWord_u got,
                         input dzPkg::regWord_u exp);
   if (got.raw !== exp.raw)
   begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got.raw, exp.raw);
      errCount++;
      abortRun();
   end
endtask

// One bit per line, for txd and dtr
task automatic checkMask(input string name, input dzPkg::lineMask_t got,
                         input dzPkg::lineMask_t exp);
   if (got !== exp)
   begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      errCount++;
      abortRun();
   end
endtask

// Small levels like ack and intr
task automatic checkFlag(input string name, input logic [3:0] got, input logic [3:0] exp);
   if (got !== exp)
   begin
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      errCount++;
      abortRun();
   end
endtask

// Ten sampled bits, start first
task automatic checkFrame(input dzPkg::lineMask_t line, input logic [9:0] got,
                          input logic [9:0] exp);
   if (got !== exp)
   begin
      $display("Error at %0t ns: txd frame on lines %b got %b expected %b",
               $time, line, got, exp);
      errCount++;
      abortRun();
   end
endtask

`endif

// File: tests/dzTb.sv
////////////////////////////////////////////////////////////
// Testbench for the transmit multiplexer
// Table driven, one step per bus operation or pin change
// Inputs change on the falling edge, outputs sampled later
// Frames sampled at bit centres on the falling edge
// Character seed comes from the seedInit parameter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dzTb #(
   parameter int seedInit = 65990
);

   localparam int               clkPeriod = 20;
   localparam int               bitClocks = 16;
   localparam int               pollLimit = 4 * bitClocks;
   localparam logic [3:0]       tbDev     = 4'd3;
   localparam logic [17:0]      tbAddr    = 18'o760010;
   localparam logic [17:0]      tbVect    = 18'o340;
   localparam logic [3:0]       tbIntr    = 4'b0100;
   // Transmit vector is four above the base
   localparam logic [17:0]      txVect    = tbVect + 18'd4;
   localparam dzPkg::lineNum_t  kLine     = 3'd5;
   localparam dzPkg::lineMask_t kMask     = 8'd1 << kLine;
   localparam dzPkg::lineMask_t allHigh   = '1;

   typedef enum logic [2:0] {opWrite, opRead, opPollTrdy, opFrame, opPins} opKind_t;

   // One table row
   typedef struct packed {
      opKind_t          op;
      dzPkg::busReq_t   req;
      logic             expAck;
      dzPkg::regWord_u  expWord;
      dzPkg::lineMask_t expMask;
      dzPkg::lineMask_t expTxd;
      logic [3:0]       expIntr;
   } step_t;

   logic             clk;
   logic             rstN;
   dzPkg::busReq_t   bus;
   dzPkg::lineMask_t carrier;
   dzPkg::lineMask_t ring;
   dzPkg::busRsp_t   rsp;
   dzPkg::lineMask_t txd;
   dzPkg::lineMask_t dtr;
   logic [3:0]       intr;

   int    seed;
   int    errCount;
   bit    tableReady;
   step_t steps[$];

   `include "dzTbChecks.svh"

   dzTop #(
      .dzDev        (tbDev),
      .dzAddr       (tbAddr),
      .dzVect       (tbVect),
      .dzIntr       (tbIntr),
      .clocksPerBit (bitClocks)
   ) i_dzTop (
      .clk     (clk),
      .rstN    (rstN),
      .bus     (bus),
      .carrier (carrier),
      .ring    (ring),
      .rsp     (rsp),
      .txd     (txd),
      .dtr     (dtr),
      .intr    (intr)
   );

   always #(clkPeriod/2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic abortRun();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   // Register access at an offset from the base
   function automatic dzPkg::busReq_t mkReq(input logic rd, input logic wr,
      input logic [17:0] offset, input logic hi, input logic lo, input logic [15:0] data);
      dzPkg::busReq_t r;
      r        = '0;
      r.read   = rd;
      r.write  = wr;
      r.io     = 1'b1;
      r.dev    = tbDev;
      r.addr   = tbAddr + offset;
      r.hiByte = hi;
      r.loByte = lo;
      r.data   = data;
      return r;
   endfunction

   function automatic logic [15:0] csrWord(input logic trdy, input logic tie,
      input dzPkg::lineNum_t tline, input logic mse, input logic clr);
      dzPkg::regWord_u w;
      w.raw       = '0;
      w.csr.trdy  = trdy;
      w.csr.tie   = tie;
      w.csr.tline = tline;
      w.csr.mse   = mse;
      w.csr.clr   = clr;
      return w.raw;
   endfunction

   // 8N1 line order: start 0, data LSB first, stop 1
   function automatic logic [9:0] frameOf(input logic [7:0] ch);
      logic [9:0] f;
      f[0] = 1'b0;
      for (int i = 0; i < 8; i++)
         f[i+1] = ch[i];
      f[9] = 1'b1;
      return f;
   endfunction

   task automatic addStep(input opKind_t op, input dzPkg::busReq_t req, input logic ack,
      input logic [15:0] word, input dzPkg::lineMask_t mask, input dzPkg::lineMask_t txdExp,
      input logic [3:0] irq);
      step_t s;
      s             = '0;
      s.op          = op;
      s.req         = req;
      s.expAck      = ack;
      s.expWord.raw = word;
      s.expMask     = mask;
      s.expTxd      = txdExp;
      s.expIntr     = irq;
      steps.push_back(s);
   endtask

   // Drive on the falling edge, settle a quarter cycle
   task automatic driveReq(input dzPkg::busReq_t req);
      @(negedge clk);
      bus = req;
      #(clkPeriod/4);
   endtask

   task automatic idleBus();
      @(negedge clk);
      bus = '0;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////

   task automatic buildTable();
      dzPkg::busReq_t r;
      logic [7:0]     ch;
      // Out of reset
      addStep(opRead, mkReq(1, 0, dzPkg::csrOffset, 1, 1, '0), 1, '0, '0, allHigh, '0);
      // TCR readback and dtr pins
      addStep(opWrite, mkReq(0, 1, dzPkg::tcrOffset, 1, 1, 16'hA53C), 1, '0, 8'hA5, allHigh, '0);
      addStep(opRead, mkReq(1, 0, dzPkg::tcrOffset, 1, 1, '0), 1, 16'hA53C, '0, allHigh, '0);
      // Foreign device and non-io cycles
      r     = mkReq(1, 0, dzPkg::tcrOffset, 1, 1, '0);
      r.dev = tbDev + 4'd1;
      addStep(opRead, r, 0, '0, '0, allHigh, '0);
      r     = mkReq(1, 0, dzPkg::tcrOffset, 1, 1, '0);
      r.io  = 1'b0;
      addStep(opRead, r, 0, '0, '0, allHigh, '0);
      // Modem pins, carrier high byte and ring low byte
      addStep(opPins, mkReq(0, 0, '0, 0, 0, 16'h9621), 0, '0, '0, allHigh, '0);
      addStep(opRead, mkReq(1, 0, dzPkg::msrTdrOffset, 1, 1, '0), 1, 16'h9621, '0, allHigh, '0);
      // Only line k, then MSE and TIE
      addStep(opWrite, mkReq(0, 1, dzPkg::tcrOffset, 1, 1, {8'h0F, kMask}), 1, '0, 8'h0F,
              allHigh, '0);
      addStep(opWrite, mkReq(0, 1, dzPkg::csrOffset, 1, 1, csrWord(0, 1, '0, 1, 0)), 1, '0,
              8'h0F, allHigh, '0);
      addStep(opPollTrdy, mkReq(1, 0, dzPkg::csrOffset, 1, 1, '0), 1, csrWord(1, 1, kLine, 1, 0),
              '0, allHigh, tbIntr);
      r      = mkReq(1, 0, '0, 1, 1, '0);
      r.vect = 1'b1;
      addStep(opRead, r, 1, txVect[15:0], '0, allHigh, tbIntr);
      // Drop TIE through the high byte only
      addStep(opWrite, mkReq(0, 1, dzPkg::csrOffset, 1, 0, '0), 1, '0, 8'h0F, allHigh, '0);
      addStep(opRead, mkReq(1, 0, dzPkg::csrOffset, 1, 1, '0), 1, csrWord(1, 0, kLine, 1, 0),
              '0, allHigh, '0);
      // Two random characters on line k
      for (int n = 0; n < 2; n++)
      begin
         ch = 8'($random(seed));
         addStep(opFrame, mkReq(0, 1, dzPkg::msrTdrOffset, 0, 1, {8'h00, ch}), 1, '0, kMask,
                 allHigh, '0);
         addStep(opPollTrdy, mkReq(1, 0, dzPkg::csrOffset, 1, 1, '0), 1,
                 csrWord(1, 0, kLine, 1, 0), '0, allHigh, '0);
      end
      // Break on line k, then clear
      addStep(opWrite, mkReq(0, 1, dzPkg::msrTdrOffset, 1, 0, {kMask, 8'h00}), 1, '0, 8'h0F,
              allHigh & ~kMask, '0);
      addStep(opWrite, mkReq(0, 1, dzPkg::csrOffset, 0, 1, csrWord(0, 0, '0, 1, 1)), 1, '0,
              '0, allHigh, '0);
      addStep(opRead, mkReq(1, 0, dzPkg::csrOffset, 1, 1, '0), 1, csrWord(0, 0, '0, 1, 0), '0,
              allHigh, '0);
      addStep(opRead, mkReq(1, 0, dzPkg::tcrOffset, 1, 1, '0), 1, '0, '0, allHigh, '0);
   endtask

   ////////////////////////////////////////////////////////////
   // Step engine
   ////////////////////////////////////////////////////////////

   task automatic applyStep(input step_t s);
      dzPkg::regWord_u got;
      logic [3:0]      gotIntr;
      logic [9:0]      frame;
      logic [9:0]      expFrame;
      int              polls;
      case (s.op)
         opWrite:
         begin
            driveReq(s.req);
            checkFlag("rsp.ack", {3'b0, rsp.ack}, {3'b0, s.expAck});
            idleBus();
            // Write has landed by now
            checkMask("dtr", dtr, s.expMask);
            checkMask("txd", txd, s.expTxd);
         end
         opRead:
         begin
            driveReq(s.req);
            got.raw = rsp.data;
            checkFlag("rsp.ack", {3'b0, rsp.ack}, {3'b0, s.expAck});
            checkWord("rsp.data", got, s.expWord);
            checkFlag("intr", intr, s.expIntr);
            idleBus();
         end
         opPollTrdy:
         begin
            polls   = 0;
            got.raw = '0;
            gotIntr = '0;
            while (!got.csr.trdy)
            begin
               if (polls == pollLimit)
               begin
                  $display("Polling CSR timed out at %0t ns, TRDY never set", $time);
                  abortRun();
               end
               else
               begin
                  driveReq(s.req);
                  got.raw = rsp.data;
                  gotIntr = intr;
                  checkFlag("rsp.ack", {3'b0, rsp.ack}, 4'd1);
                  idleBus();
                  polls++;
               end
            end
            checkWord("CSR", got, s.expWord);
            checkFlag("intr", gotIntr, s.expIntr);
         end
         opFrame:
         begin
            expFrame = frameOf(s.req.data[7:0]);
            driveReq(s.req);
            checkFlag("rsp.ack", {3'b0, rsp.ack}, {3'b0, s.expAck});
            // Half a cycle past the write edge, then to the first bit centre
            idleBus();
            repeat (bitClocks/2) @(negedge clk);
            for (int b = 0; b < 10; b++)
            begin
               if (b > 0)
                  repeat (bitClocks) @(negedge clk);
               frame[b] = |(txd & s.expMask);
               // Idle lines stay at mark
               checkMask("txd other lines", txd & ~s.expMask, allHigh & ~s.expMask);
            end
            checkFrame(s.expMask, frame, expFrame);
         end
         opPins:
         begin
            @(negedge clk);
            carrier = s.req.data[15:8];
            ring    = s.req.data[7:0];
            // Two sync stages plus one spare
            repeat (3) @(negedge clk);
         end
         default:
         begin
            $display("Unknown table operation at %0t ns", $time);
            abortRun();
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk        = 1'b0;
      rstN       = 1'b0;
      bus        = '0;
      carrier    = '0;
      ring       = '0;
      errCount   = 0;
      tableReady = 1'b0;
      seed       = seedInit;
      buildTable();
      tableReady = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      foreach (steps[i])
         applyStep(steps[i]);
      repeat (2) @(negedge clk);
      if (errCount == 0)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
         abortRun();
   end

   // Twelve bit times per step is far above any step's length
   initial
   begin
      longint limitNs;
      wait (tableReady);
      limitNs = longint'(steps.size()) * 12 * bitClocks * clkPeriod + 200 * clkPeriod;
      #(limitNs);
      $display("Watchdog expired after %0d ns, the run hung", limitNs);
      abortRun();
   end

endmodule

// File: src/dzTop.sv
////////////////////////////////////////////////////////////
// Transmit side of an eight-line terminal multiplexer
// Bus acknowledge and read data are combinational
// Bit rate is fixed by clocksPerBit for all lines
// No receivers and no line parameter register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dzTop #(
   parameter logic [3:0]  dzDev        = 4'd3,
   parameter logic [17:0] dzAddr       = 18'o760010,
   parameter logic [17:0] dzVect       = 18'o340,
   parameter logic [3:0]  dzIntr       = 4'b0100,
   parameter int          clocksPerBit = 16
) (
   input  logic             clk,
   input  logic             rstN,
   input  dzPkg::busReq_t   bus,
   input  dzPkg::lineMask_t carrier,
   input  dzPkg::lineMask_t ring,
   output dzPkg::busRsp_t   rsp,
   output dzPkg::lineMask_t txd,
   output dzPkg::lineMask_t dtr,
   output logic [3:0]       intr
);

   // Controller to scanner
   logic             mse;
   dzPkg::lineMask_t lineEnable;
   logic [1:0]       tdrWrite;
   dzPkg::tdr_t      tdrWord;
   logic             init;

   // Scanner status
   logic             trdy;
   dzPkg::lineNum_t  tline;

   // Scanner to transmitters
   dzPkg::lineMask_t load;
   logic [7:0]       txChar;
   dzPkg::lineMask_t brk;
   dzPkg::lineMask_t empty;

   dzPkg::msr_t      msr;

   ////////////////////////////////////////////////////////////
   // Register file and bus interface
   ////////////////////////////////////////////////////////////

   dzBusCtrl #(
      .dzDev  (dzDev),
      .dzAddr (dzAddr),
      .dzVect (dzVect),
      .dzIntr (dzIntr)
   ) i_dzBusCtrl (
      .clk        (clk),
      .rstN       (rstN),
      .bus        (bus),
      .msr        (msr),
      .trdy       (trdy),
      .tline      (tline),
      .rsp        (rsp),
      .mse        (mse),
      .lineEnable (lineEnable),
      .dtr        (dtr),
      .tdrWrite   (tdrWrite),
      .tdrWord    (tdrWord),
      .init       (init),
      .intr       (intr)
   );

   // Round-robin line search and character steering
   dzTxScan i_dzTxScan (
      .clk        (clk),
      .rstN       (rstN),
      .init       (init),
      .mse        (mse),
      .lineEnable (lineEnable),
      .empty      (empty),
      .tdrWrite   (tdrWrite),
      .tdrWord    (tdrWord),
      .trdy       (trdy),
      .tline      (tline),
      .load       (load),
      .txChar     (txChar),
      .brk        (brk)
   );

   // Carrier and ring into the clock domain
   dzModemSync i_dzModemSync (
      .clk     (clk),
      .rstN    (rstN),
      .carrier (carrier),
      .ring    (ring),
      .msr     (msr)
   );

   ////////////////////////////////////////////////////////////
   // Transmitter array
   ////////////////////////////////////////////////////////////

   for (genvar k = 0; k < dzPkg::nLines; k++)
   begin : gLine
      dzUartTx #(
         .clocksPerBit (clocksPerBit)
      ) i_dzUartTx (
         .clk    (clk),
         .rstN   (rstN),
         .init   (init),
         .load   (load[k]),
         .txChar (txChar),
         .brk    (brk[k]),
         .txd    (txd[k]),
         .empty  (empty[k])
      );
   end

endmodule

// File: src/dzBusCtrl.sv
////////////////////////////////////////////////////////////
// Bus decode, CSR and TCR, read mux and interrupt request
// Same-cycle ack and read data, writes land on next edge
// CLR is a one-shot and always reads back as zero
// tdrWrite carries the high and low byte lane strobes
// Interrupt is a level, vector read has no side effect
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dzBusCtrl #(
   parameter logic [3:0]  dzDev  = '0,
   parameter logic [17:0] dzAddr = '0,
   parameter logic [17:0] dzVect = '0,
   parameter logic [3:0]  dzIntr = '0
) (
   input  logic             clk,
   input  logic             rstN,
   input  dzPkg::busReq_t   bus,
   input  dzPkg::msr_t      msr,
   input  logic             trdy,
   input  dzPkg::lineNum_t  tline,
   output dzPkg::busRsp_t   rsp,
   output logic             mse,
   output dzPkg::lineMask_t lineEnable,
   output dzPkg::lineMask_t dtr,
   output logic [1:0]       tdrWrite,
   output dzPkg::tdr_t      tdrWord,
   output logic             init,
   output logic [3:0]       intr
);

   // Absolute register addresses
   localparam logic [17:0] csrAddr = dzAddr + dzPkg::csrOffset;
   localparam logic [17:0] tcrAddr = dzAddr + dzPkg::tcrOffset;
   localparam logic [17:0] mtAddr  = dzAddr + dzPkg::msrTdrOffset;

   // Only the transmit vector remains
   localparam logic [17:0] txVect  = dzVect + 18'd4;

   logic devSel;
   logic regSel;
   logic csrRead;
   logic csrWrite;
   logic tcrRead;
   logic tcrWrite;
   logic msrRead;
   logic tdrSel;
   logic vectRead;

   logic           tie;
   dzPkg::tcr_t    tcr;
   dzPkg::regWord_u wrWord;
   dzPkg::regWord_u rdWord;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   assign devSel   = bus.io && (bus.dev == dzDev);
   assign regSel   = devSel && !bus.vect;

   assign csrRead  = regSel && bus.read  && (bus.addr == csrAddr);
   assign csrWrite = regSel && bus.write && (bus.addr == csrAddr);
   assign tcrRead  = regSel && bus.read  && (bus.addr == tcrAddr);
   assign tcrWrite = regSel && bus.write && (bus.addr == tcrAddr);
   // Same offset, direction picks MSR or TDR
   assign msrRead  = regSel && bus.read  && (bus.addr == mtAddr);
   assign tdrSel   = regSel && bus.write && (bus.addr == mtAddr);
   assign vectRead = devSel && bus.vect && bus.read;

   // Write data seen through the register layouts
   assign wrWord.raw = bus.data;

   // Clear pulse from a CSR low byte write
   assign init = csrWrite && bus.loByte && wrWord.csr.clr;

   // TDR byte lanes to the scanner
   assign tdrWrite = {tdrSel && bus.hiByte, tdrSel && bus.loByte};
   assign tdrWord  = wrWord.tdr;

   ////////////////////////////////////////////////////////////
   // CSR and TCR
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         mse <= 1'b0;
         tie <= 1'b0;
         tcr <= '0;
      end
      else
      begin
         // TIE in high byte, MSE in low byte
         if (csrWrite && bus.hiByte)
            tie <= wrWord.csr.tie;
         if (csrWrite && bus.loByte)
            mse <= wrWord.csr.mse;
         // Clear wipes TCR but leaves MSE and TIE
         if (init)
            tcr <= '0;
         else if (tcrWrite)
         begin
            if (bus.hiByte)
               tcr.dtr <= wrWord.tcr.dtr;
            if (bus.loByte)
               tcr.lineEnable <= wrWord.tcr.lineEnable;
         end
      end
   end

   assign lineEnable = tcr.lineEnable;
   assign dtr        = tcr.dtr;

   ////////////////////////////////////////////////////////////
   // Read mux and acknowledge
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      rdWord.raw = '0;
      if (csrRead)
      begin
         rdWord.csr.trdy  = trdy;
         rdWord.csr.tie   = tie;
         rdWord.csr.tline = tline;
         rdWord.csr.mse   = mse;
      end
      else if (tcrRead)
         rdWord.tcr = tcr;
      else if (msrRead)
         rdWord.msr = msr;
      else if (vectRead)
         rdWord.raw = txVect[15:0];
   end

   assign rsp.ack  = csrRead | csrWrite | tcrRead | tcrWrite |
                     msrRead | tdrSel | vectRead;
   assign rsp.data = rdWord.raw;

   // Level request while a line waits for a character
   assign intr = (tie && trdy) ? dzIntr : 4'b0;

   // One register target per bus cycle
   aOneSelect: assert property (@(posedge clk) disable iff (!rstN)
      $onehot0({csrRead, csrWrite, tcrRead, tcrWrite, msrRead, tdrSel, vectRead}));

endmodule

// File: src/dzTxScan.sv
////////////////////////////////////////////////////////////
// Round-robin search for an enabled and empty line
// Pointer moves one line per cycle while MSE and not TRDY
// Character write without TRDY is dropped
// Break bits are held here and cleared by init
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dzTxScan (
   input  logic             clk,
   input  logic             rstN,
   input  logic             init,
   input  logic             mse,
   input  dzPkg::lineMask_t lineEnable,
   input  dzPkg::lineMask_t empty,
   input  logic [1:0]       tdrWrite,
   input  dzPkg::tdr_t      tdrWord,
   output logic             trdy,
   output dzPkg::lineNum_t  tline,
   output dzPkg::lineMask_t load,
   output logic [7:0]       txChar,
   output dzPkg::lineMask_t brk
);

   dzPkg::lineNum_t scanPtr;
   logic            hit;
   logic            charWrite;

   // Line under the pointer wants a character
   assign hit       = lineEnable[scanPtr] && empty[scanPtr];
   assign charWrite = tdrWrite[0] && trdy;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         trdy    <= 1'b0;
         tline   <= '0;
         scanPtr <= '0;
         load    <= '0;
         brk     <= '0;
      end
      else
      begin
         // Load is a single cycle pulse
         load <= '0;
         if (init)
         begin
            // Scanner back to its reset state
            trdy    <= 1'b0;
            tline   <= '0;
            scanPtr <= '0;
            brk     <= '0;
         end
         else
         begin
            if (tdrWrite[1])
               brk <= tdrWord.brk;
            if (charWrite)
            begin
               load[tline] <= 1'b1;
               trdy        <= 1'b0;
               // Resume after the line just served
               scanPtr     <= tline + 1'b1;
            end
            else if (mse && !trdy)
            begin
               if (hit)
               begin
                  trdy  <= 1'b1;
                  tline <= scanPtr;
               end
               else
                  scanPtr <= scanPtr + 1'b1;
            end
         end
      end
   end

   // Character travels with the load pulse
   always_ff @(posedge clk)
   begin
      if (charWrite)
         txChar <= tdrWord.tbuf;
   end

   // Single line per load, and only into an idle transmitter
   aLoadOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(load));
   aLoadEmpty: assert property (@(posedge clk) disable iff (!rstN) (load & ~empty) == '0);

endmodule

// File: src/dzUartTx.sv
////////////////////////////////////////////////////////////
// Fixed-rate 8N1 transmitter
// Start bit begins on the edge after load
// empty stays low for ten bit times
// brk forces the line low regardless of state
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dzUartTx #(
   parameter int clocksPerBit = 16
) (
   input  logic       clk,
   input  logic       rstN,
   input  logic       init,
   input  logic       load,
   input  logic [7:0] txChar,
   input  logic       brk,
   output logic       txd,
   output logic       empty
);

   localparam int              cntW     = (clocksPerBit > 1) ? $clog2(clocksPerBit) : 1;
   localparam logic [cntW-1:0] lastTick = cntW'(clocksPerBit - 1);

   logic            busy;
   logic [cntW-1:0] tickCnt;
   logic [3:0]      bitsLeft;
   // Stop, data LSB first, start
   logic [9:0]      shiftReg;
   logic            bitDone;

   assign bitDone = (tickCnt == lastTick);

   ////////////////////////////////////////////////////////////
   // Bit timing
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN || init)
      begin
         busy     <= 1'b0;
         tickCnt  <= '0;
         bitsLeft <= '0;
      end
      else if (load)
      begin
         busy     <= 1'b1;
         tickCnt  <= '0;
         bitsLeft <= 4'd10;
      end
      else if (busy)
      begin
         if (bitDone)
         begin
            tickCnt  <= '0;
            bitsLeft <= bitsLeft - 4'd1;
            // Stop bit done
            if (bitsLeft == 4'd1)
               busy <= 1'b0;
         end
         else
            tickCnt <= tickCnt + 1'b1;
      end
   end

   // Frame shifter
   always_ff @(posedge clk)
   begin
      if (load)
         shiftReg <= {1'b1, txChar, 1'b0};
      else if (busy && bitDone)
         shiftReg <= {1'b1, shiftReg[9:1]};
   end

   // Idle mark unless sending, break wins
   assign txd   = brk ? 1'b0 : (busy ? shiftReg[0] : 1'b1);
   assign empty = !busy;

   // Scanner only loads idle lines
   aNoLoadBusy: assert property (@(posedge clk) disable iff (!rstN) load |-> !busy);

endmodule

// File: src/dzModemSync.sv
////////////////////////////////////////////////////////////
// Carrier and ring synchronizer
// Pins are asynchronous, two flops per pin
// A pin change shows in MSR after two clock edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dzModemSync (
   input  logic             clk,
   input  logic             rstN,
   input  dzPkg::lineMask_t carrier,
   input  dzPkg::lineMask_t ring,
   output dzPkg::msr_t      msr
);

   // First stage, may go metastable
   dzPkg::msr_t meta;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         meta <= '0;
         msr  <= '0;
      end
      else
      begin
         meta.carrier <= carrier;
         meta.ring    <= ring;
         // Second stage feeds the register read
         msr          <= meta;
      end
   end

endmodule

// File: src/dzPkg.sv
////////////////////////////////////////////////////////////
// Shared types for the eight-line transmit multiplexer
// Register words are 16 bits and map onto the bus data path
// Offsets are byte offsets from the device base address
// MSR read and TDR write share one offset
////////////////////////////////////////////////////////////

package dzPkg;

   // Line count and derived types
   localparam int nLines = 8;

   typedef logic [nLines-1:0]         lineMask_t;
   typedef logic [$clog2(nLines)-1:0] lineNum_t;

   // Register offsets
   localparam logic [17:0] csrOffset    = 18'd0;
   localparam logic [17:0] tcrOffset    = 18'd4;
   localparam logic [17:0] msrTdrOffset = 18'd6;

   ////////////////////////////////////////////////////////////
   // Bus request and response
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic        read;
      logic        write;
      logic        io;
      logic        vect;
      logic [3:0]  dev;
      logic [17:0] addr;
      logic        hiByte;
      logic        loByte;
      logic [15:0] data;
   } busReq_t;

   typedef struct packed {
      logic        ack;
      logic [15:0] data;
   } busRsp_t;

   ////////////////////////////////////////////////////////////
   // Register layouts
   ////////////////////////////////////////////////////////////

   // Control and status
   typedef struct packed {
      logic       trdy;
      logic       tie;
      logic [2:0] rsvdHi;
      lineNum_t   tline;
      logic [1:0] rsvdMid;
      logic       mse;
      logic       clr;
      logic [3:0] rsvdLo;
   } csr_t;

   // Transmit control
   typedef struct packed {
      lineMask_t dtr;
      lineMask_t lineEnable;
   } tcr_t;

   // Modem status, read only
   typedef struct packed {
      lineMask_t carrier;
      lineMask_t ring;
   } msr_t;

   // Transmit data, write only
   typedef struct packed {
      lineMask_t  brk;
      logic [7:0] tbuf;
   } tdr_t;

   // One bus word, decoded by address and direction
   typedef union packed {
      logic [15:0] raw;
      csr_t        csr;
      tcr_t        tcr;
      msr_t        msr;
      tdr_t        tdr;
   } regWord_u;

endpackage
